// File: hdl/eth_crc32_step.sv
module eth_crc32_step (
    input  logic [31:0] data,
    input  logic [31:0] state_in,
    output logic [31:0] state_1,
    output logic [31:0] state_2,
    output logic [31:0] state_3,
    output logic [31:0] state_4
);

    // fold one byte in, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ xgmii_pkg::ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // chained bytewise, each partial result exposed
    always_comb begin
        state_1 = crc_byte(state_in, data[7:0]);
        state_2 = crc_byte(state_1, data[15:8]);
        state_3 = crc_byte(state_2, data[23:16]);
        state_4 = crc_byte(state_3, data[31:24]);
    end

endmodule

// File: hdl/rx_beat_fifo.sv
module rx_beat_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  logic                    wr_en,
    input  rx_stream_pkg::rx_beat_t wr_beat,
    input  logic                    rd_en,
    output rx_stream_pkg::rx_beat_t rd_beat,
    output logic                    empty,
    output logic                    overflow
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    rx_stream_pkg::rx_beat_t mem [DEPTH];

    // extra msb tells full from empty
    logic [FIFO_DEPTH_LOG2:0] wr_ptr, rd_ptr;
    logic full;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                  (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign rd_beat = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // beat lost, held until reset
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hdl/rx_frame_stats.sv
module rx_frame_stats (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  logic                     freeze,
    input  logic                     empty,
    input  rx_stream_pkg::rx_beat_t  head,
    output logic                     rd_en,
    output rx_stream_pkg::rx_stats_t stats
);

    // bytes seen so far in the current frame
    logic [15:0] frame_bytes;
    logic [2:0]  keep_count;
    logic [15:0] frame_total;

    // head beat is consumed in the same cycle as the pop
    assign rd_en = !empty && !freeze;

    assign keep_count = 3'($countones(head.keep));
    assign frame_total = frame_bytes + 16'(keep_count);

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            frame_bytes <= '0;
            stats <= '0;
        end else if (rd_en) begin
            if (head.last) begin
                frame_bytes <= '0;
                if (head.bad) begin
                    stats.bad_frames <= stats.bad_frames + 1'b1;
                    if (head.fcs_bad) begin
                        stats.fcs_errors <= stats.fcs_errors + 1'b1;
                    end
                end else begin
                    stats.good_frames <= stats.good_frames + 1'b1;
                    stats.good_bytes <= stats.good_bytes + 32'(frame_total);
                end
            end else begin
                frame_bytes <= frame_total;
            end
        end
    end

endmodule

// File: hdl/rx_stream_pkg.sv
package rx_stream_pkg;

    // one receive beat out of the decoder
    typedef struct packed {
        logic [31:0] data;
        // byte enables, lane 0 first
        logic [3:0]  keep;
        logic        last;
        // frame in error
        logic        bad;
        // frame failed the FCS check
        logic        fcs_bad;
    } rx_beat_t;

    // frame statistics
    typedef struct packed {
        logic [31:0] good_frames;
        logic [31:0] bad_frames;
        logic [31:0] fcs_errors;
        logic [31:0] good_bytes;
    } rx_stats_t;

endpackage

// File: hdl/xgmii_pkg.sv
package xgmii_pkg;

    // one XGMII receive word, four byte lanes with lane 0 in rxd[7:0]
    typedef struct packed {
        logic [31:0] rxd;
        logic [3:0]  rxc;
    } xgmii_word_t;

    // control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // ethernet CRC-32, reflected form
    localparam logic [31:0] ETH_CRC_POLY = 32'hedb8_8320;
    localparam logic [31:0] ETH_CRC_INIT = 32'hffff_ffff;

    // running state after a correct FCS is folded in, no final inversion
    localparam logic [31:0] ETH_CRC_RESIDUE = 32'hdebb_20e3;

endpackage

// File: hdl/xgmii_rx_decoder.sv
module xgmii_rx_decoder (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  xgmii_pkg::xgmii_word_t  xgmii_in,
    output rx_stream_pkg::rx_beat_t beat,
    output logic                    beat_valid,
    output logic                    error_bad_frame,
    output logic                    error_bad_fcs
);

    // decoded word as it moves down the delay line
    typedef struct packed {
        logic [31:0] data;
        logic        start;
        logic        start_bad;
        logic [3:0]  term;
        logic        ctrl_err;
        logic [3:0]  keep;
    } stage_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_LAST
    } state_t;

    state_t state, state_next;

    xgmii_pkg::xgmii_word_t d0;
    stage_t d0_dec, d1, d2;

    logic        crc_restart;
    logic [31:0] crc_state;
    logic [31:0] crc_1, crc_2, crc_3, crc_4;
    logic [3:0]  crc_match, crc_match_save;
    logic        fcs_ok;

    rx_stream_pkg::rx_beat_t beat_next;
    logic beat_valid_next, bad_frame_next, bad_fcs_next;

    // CRC runs on stage 1, one word ahead of the FSM
    eth_crc32_step u_crc (
        .data    (d1.data),
        .state_in(crc_state),
        .state_1 (crc_1),
        .state_2 (crc_2),
        .state_3 (crc_3),
        .state_4 (crc_4)
    );

    assign crc_match = {crc_4 == xgmii_pkg::ETH_CRC_RESIDUE,
                        crc_3 == xgmii_pkg::ETH_CRC_RESIDUE,
                        crc_2 == xgmii_pkg::ETH_CRC_RESIDUE,
                        crc_1 == xgmii_pkg::ETH_CRC_RESIDUE};

    // character detection on the newest word
    always_comb begin
        d0_dec.data = d0.rxd;
        for (int i = 0; i < 4; i++) begin
            d0_dec.term[i] = d0.rxc[i] && (d0.rxd[i*8 +: 8] == xgmii_pkg::XGMII_TERM);
        end
        // lanes in front of the first terminate
        casez (d0_dec.term)
            4'b???1: d0_dec.keep = 4'b0000;
            4'b??10: d0_dec.keep = 4'b0001;
            4'b?100: d0_dec.keep = 4'b0011;
            4'b1000: d0_dec.keep = 4'b0111;
            default: d0_dec.keep = 4'b1111;
        endcase
        // error or stray control inside the frame
        d0_dec.ctrl_err = |(d0.rxc & d0_dec.keep);
        d0_dec.start = d0.rxc[0] && (d0.rxd[7:0] == xgmii_pkg::XGMII_START);
        d0_dec.start_bad = |d0.rxc[3:1];
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            d0 <= '0;
            d1 <= '0;
            d2 <= '0;
        end else begin
            d0 <= xgmii_in;
            d1 <= d0_dec;
            d2 <= d1;
        end
    end

    // partial FCS match picked by where the terminate sat
    always_comb begin
        case (d2.keep)
            4'b0001: fcs_ok = crc_match_save[0];
            4'b0011: fcs_ok = crc_match_save[1];
            4'b0111: fcs_ok = crc_match_save[2];
            default: fcs_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        crc_restart = 1'b0;
        beat_next = '0;
        beat_next.data = d2.data;
        beat_next.keep = 4'b1111;
        beat_valid_next = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next = 1'b0;

        case (state)
            ST_IDLE: begin
                crc_restart = 1'b1;
                if (d2.start) begin
                    if (d2.start_bad) begin
                        // control in the start word, flag it as a stub frame
                        beat_next.data = '0;
                        beat_next.keep = 4'b0001;
                        beat_next.last = 1'b1;
                        beat_next.bad = 1'b1;
                        beat_valid_next = 1'b1;
                        bad_frame_next = 1'b1;
                    end else begin
                        state_next = ST_PREAMBLE;
                    end
                end
            end
            ST_PREAMBLE: begin
                // preamble word is dropped
                state_next = ST_PAYLOAD;
            end
            ST_PAYLOAD: begin
                beat_valid_next = 1'b1;
                if (d2.ctrl_err) begin
                    beat_next.keep = d2.keep;
                    beat_next.last = 1'b1;
                    beat_next.bad = 1'b1;
                    bad_frame_next = 1'b1;
                    state_next = ST_IDLE;
                end else if (d1.term[0]) begin
                    // terminate in lane 0 of the next word, this one ends the frame
                    beat_next.last = 1'b1;
                    if (!crc_match_save[3]) begin
                        beat_next.bad = 1'b1;
                        beat_next.fcs_bad = 1'b1;
                        bad_frame_next = 1'b1;
                        bad_fcs_next = 1'b1;
                    end
                    state_next = ST_IDLE;
                end else if (|d1.term) begin
                    state_next = ST_LAST;
                end
            end
            ST_LAST: begin
                crc_restart = 1'b1;
                beat_next.keep = d2.keep;
                beat_next.last = 1'b1;
                beat_valid_next = 1'b1;
                if (d2.ctrl_err) begin
                    beat_next.bad = 1'b1;
                    bad_frame_next = 1'b1;
                end else if (!fcs_ok) begin
                    beat_next.bad = 1'b1;
                    beat_next.fcs_bad = 1'b1;
                    bad_frame_next = 1'b1;
                    bad_fcs_next = 1'b1;
                end
                state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_state <= xgmii_pkg::ETH_CRC_INIT;
        end else begin
            crc_state <= crc_4;
        end
        if (reset_crc) begin
            crc_match_save <= '0;
        end else begin
            crc_match_save <= crc_match;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= ST_IDLE;
            beat_valid <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
        end else begin
            state <= state_next;
            beat_valid <= beat_valid_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs <= bad_fcs_next;
        end
        beat <= beat_next;
    end

endmodule

// File: hdl/xgmii_rx_top.sv
module xgmii_rx_top #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_pkg::xgmii_word_t   xgmii_in,
    input  logic                     freeze,
    output rx_stream_pkg::rx_stats_t stats,
    output logic                     overflow,
    output logic                     error_bad_frame,
    output logic                     error_bad_fcs
);

    rx_stream_pkg::rx_beat_t beat, head;
    logic beat_valid, fifo_empty, fifo_rd_en;

    xgmii_rx_decoder u_decoder (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .xgmii_in       (xgmii_in),
        .beat           (beat),
        .beat_valid     (beat_valid),
        .error_bad_frame(error_bad_frame),
        .error_bad_fcs  (error_bad_fcs)
    );

    rx_beat_fifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk      (clk),
        .reset_crc(reset_crc),
        .wr_en    (beat_valid),
        .wr_beat  (beat),
        .rd_en    (fifo_rd_en),
        .rd_beat  (head),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    rx_frame_stats u_stats (
        .clk      (clk),
        .reset_crc(reset_crc),
        .freeze   (freeze),
        .empty    (fifo_empty),
        .head     (head),
        .rd_en    (fifo_rd_en),
        .stats    (stats)
    );

endmodule

// File: project.f
hdl/xgmii_pkg.sv
hdl/rx_stream_pkg.sv
hdl/eth_crc32_step.sv
hdl/xgmii_rx_decoder.sv
hdl/rx_beat_fifo.sv
hdl/rx_frame_stats.sv
hdl/xgmii_rx_top.sv
verif/tb_xgmii_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the XGMII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_xgmii_rx -f project.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

// File: verif/tb_xgmii_rx.sv
module tb_xgmii_rx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam xgmii_pkg::xgmii_word_t IDLE_WORD = {32'h0707_0707, 4'hf};

    logic                     clk;
    logic                     reset_crc;
    xgmii_pkg::xgmii_word_t   xgmii_in;
    logic                     freeze;
    rx_stream_pkg::rx_stats_t stats;
    logic                     overflow;
    logic                     error_bad_frame;
    logic                     error_bad_fcs;

    // expected statistics and event counts
    logic [31:0] exp_good, exp_bad, exp_fcs, exp_bytes;
    logic [31:0] exp_fcs_pulses, exp_frame_pulses;
    int          exp_frames;
    int          frames_out, fcs_pulses, frame_pulses;
    int          errors, checks;
    logic [31:0] rng;
    rx_stream_pkg::rx_stats_t snap;

    xgmii_rx_top #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_xgmii_rx_top (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .xgmii_in       (xgmii_in),
        .freeze         (freeze),
        .stats          (stats),
        .overflow       (overflow),
        .error_bad_frame(error_bad_frame),
        .error_bad_fcs  (error_bad_fcs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // pulses and frame ends leaving the decoder
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (error_bad_fcs) begin
                fcs_pulses++;
            end
            if (error_bad_frame) begin
                frame_pulses++;
            end
            if (u_xgmii_rx_top.beat_valid && u_xgmii_rx_top.beat.last) begin
                frames_out++;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // bitwise reference CRC-32 in reflected form
    function automatic logic [31:0] crc_fold(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_stats();
        check_value("stats.good_frames", stats.good_frames, exp_good);
        check_value("stats.bad_frames", stats.bad_frames, exp_bad);
        check_value("stats.fcs_errors", stats.fcs_errors, exp_fcs);
        check_value("stats.good_bytes", stats.good_bytes, exp_bytes);
        check_value("error_bad_fcs pulses", 32'(fcs_pulses), exp_fcs_pulses);
        check_value("error_bad_frame pulses", 32'(frame_pulses), exp_frame_pulses);
    endtask

    task automatic send_word(input xgmii_pkg::xgmii_word_t w);
        @(negedge clk);
        xgmii_in = w;
    endtask

    // mode 0 good, 1 FCS bit flip, 2 error char in payload, 3 control in start word
    task automatic send_frame(input int len, input int mode);
        logic [7:0]  bytes[$];
        logic        ctrl[$];
        logic [31:0] crc, r;
        int          n, idx;
        xgmii_pkg::xgmii_word_t w;
        crc = 32'hffff_ffff;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            bytes.push_back(r[7:0]);
            ctrl.push_back(1'b0);
            crc = crc_fold(crc, r[7:0]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(crc[i*8 +: 8]);
            ctrl.push_back(1'b0);
        end
        n = bytes.size();
        r = next_rand();
        if (mode == 1) begin
            idx = len + int'(r[4:3]);
            bytes[idx] = bytes[idx] ^ (8'h01 << r[2:0]);
        end else if (mode == 2) begin
            idx = int'(r % 32'(len));
            bytes[idx] = xgmii_pkg::XGMII_ERROR;
            ctrl[idx] = 1'b1;
        end
        w.rxd = {24'h55_5555, xgmii_pkg::XGMII_START};
        w.rxc = 4'b0001;
        if (mode == 3) begin
            w.rxd[15:8] = xgmii_pkg::XGMII_ERROR;
            w.rxc = 4'b0011;
        end
        send_word(w);
        send_word({32'hd555_5555, 4'h0});
        // the last pass carries the terminate in lane n mod 4
        for (int pos = 0; pos <= n; pos += 4) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (pos + lane < n) begin
                    w.rxd[lane*8 +: 8] = bytes[pos+lane];
                    w.rxc[lane] = ctrl[pos+lane];
                end else if (pos + lane == n) begin
                    w.rxd[lane*8 +: 8] = xgmii_pkg::XGMII_TERM;
                    w.rxc[lane] = 1'b1;
                end else begin
                    w.rxd[lane*8 +: 8] = xgmii_pkg::XGMII_IDLE;
                    w.rxc[lane] = 1'b1;
                end
            end
            send_word(w);
        end
        r = next_rand();
        repeat (1 + int'(r % 32'd3)) send_word(IDLE_WORD);
        exp_frames++;
        if (mode == 0) begin
            exp_good++;
            exp_bytes += 32'(n);
        end else begin
            exp_bad++;
            exp_frame_pulses++;
            if (mode == 1) begin
                exp_fcs++;
                exp_fcs_pulses++;
            end
        end
    endtask

    task automatic wait_frames();
        int cycles;
        cycles = 0;
        while (frames_out < exp_frames && cycles < 500) begin
            @(posedge clk);
            cycles++;
        end
        assert (frames_out >= exp_frames) else begin
            $display("timeout: decoder ended %0d of %0d frames", frames_out, exp_frames);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!u_xgmii_rx_top.fifo_empty && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        assert (u_xgmii_rx_top.fifo_empty) else begin
            $display("timeout: beat FIFO did not drain");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e;
        reset_crc = 1'b1;
        xgmii_in = IDLE_WORD;
        freeze = 1'b0;
        rng = 32'h1d45_fa2c;
        {exp_good, exp_bad, exp_fcs, exp_bytes} = '0;
        {exp_fcs_pulses, exp_frame_pulses} = '0;
        exp_frames = 0;
        frames_out = 0;
        fcs_pulses = 0;
        frame_pulses = 0;
        errors = 0;
        checks = 0;
        repeat (2) @(negedge clk);
        reset_crc = 1'b0;

        e = errors;
        check_value("overflow", 32'(overflow), 32'd0);
        check_stats();
        for (int i = 0; i < 12; i++) begin
            send_frame(8 + int'(next_rand() % 32'd57), 0);
        end
        wait_frames();
        wait_drain();
        check_stats();
        report_test("test 1 random good frames", e);

        e = errors;
        for (int lane = 0; lane < 4; lane++) begin
            send_frame(4 * (2 + int'(next_rand() % 32'd14)) + lane, 0);
        end
        wait_frames();
        wait_drain();
        check_stats();
        report_test("test 2 terminate in each lane", e);

        e = errors;
        for (int i = 0; i < 4; i++) begin
            send_frame(8 + int'(next_rand() % 32'd57), 1);
        end
        wait_frames();
        wait_drain();
        check_stats();
        report_test("test 3 FCS errors", e);

        e = errors;
        for (int i = 0; i < 3; i++) begin
            send_frame(8 + int'(next_rand() % 32'd57), 2);
        end
        send_frame(20, 3);
        send_frame(33, 3);
        wait_frames();
        wait_drain();
        check_stats();
        report_test("test 4 control characters", e);

        // 44 bytes on the wire make 11 beats and fit in the FIFO
        e = errors;
        snap = {exp_good, exp_bad, exp_fcs, exp_bytes};
        @(negedge clk);
        freeze = 1'b1;
        send_frame(40, 0);
        wait_frames();
        // give the last beat time to reach the FIFO head
        repeat (4) @(negedge clk);
        check_value("stats.good_frames", stats.good_frames, snap.good_frames);
        check_value("stats.good_bytes", stats.good_bytes, snap.good_bytes);
        check_value("stats.bad_frames", stats.bad_frames, snap.bad_frames);
        check_value("stats.fcs_errors", stats.fcs_errors, snap.fcs_errors);
        freeze = 1'b0;
        wait_drain();
        check_stats();
        check_value("overflow", 32'(overflow), 32'd0);
        report_test("test 5 freeze within depth", e);

        e = errors;
        @(negedge clk);
        freeze = 1'b1;
        send_frame(40, 0);
        send_frame(40, 0);
        wait_frames();
        @(negedge clk);
        check_value("overflow", 32'(overflow), 32'd1);
        freeze = 1'b0;
        report_test("test 6 overflow", e);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
